// File: files.f
src/rv_pkg.sv
src/instr_decoder.sv
src/reg_file.sv
src/alu.sv
src/exec_core.sv
sim/tb_clock_gen.sv
sim/exec_core_properties.sv
sim/exec_core_tb.sv

// File: sim/exec_core_tb.sv
`timescale 1ns/10ps

module exec_core_tb;

	// one table row, applied per cycle
	typedef struct packed {
		logic        valid;
		logic [31:0] instr;
		logic        we;
		logic [4:0]  rd;
		logic [31:0] data;
		logic        taken;
		logic [31:0] next_pc;
	} step_t;

	logic        clk;
	logic        rst_n;
	logic        instr_valid;
	logic [31:0] instr;
	logic [31:0] pc;
	logic        wb_en;
	logic [4:0]  wb_rd;
	logic [31:0] wb_data;
	logic        branch_taken;

	step_t       steps[$];
	logic [31:0] model_pc = 32'h0; // expected pc while the table is built
	int          errors = 0;
	int          passed = 0;
	int          failed = 0;
	int          cycles = 0;
	int          cycle_limit = 0; // 0 until the table is known

	tb_clock_gen u_clk_gen (.o_clk(clk), .o_rst_n(rst_n));

	exec_core dut (
		.i_clk          (clk),
		.i_rst_n        (rst_n),
		.i_instr_valid  (instr_valid),
		.i_instr        (instr),
		.o_pc           (pc),
		.o_wb_en        (wb_en),
		.o_wb_rd        (wb_rd),
		.o_wb_data      (wb_data),
		.o_branch_taken (branch_taken)
	);

	// rv32i instruction formats
	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] enc_b(input int off, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		logic [12:0] im;
		im = off[12:0];
		return {im[12], im[10:5], rs2, rs1, f3, im[4:1], im[11], 7'b1100011};
	endfunction

	task automatic add_step(input logic valid, input logic [31:0] ins, input logic we,
			input logic [4:0] rd, input logic [31:0] data, input logic taken, input int pc_step);
		step_t s;
		model_pc  = model_pc + pc_step;
		s.valid   = valid;
		s.instr   = ins;
		s.we      = we;
		s.rd      = rd;
		s.data    = data;
		s.taken   = taken;
		s.next_pc = model_pc;
		steps.push_back(s);
	endtask

	task automatic alu_step(input logic [31:0] ins, input logic [4:0] rd,
			input logic [31:0] data);
		add_step(1'b1, ins, 1'b1, rd, data, 1'b0, 4);
	endtask

	// taken moves by the offset, otherwise by 4
	task automatic branch_step(input logic [2:0] f3, input logic [4:0] rs1,
			input logic [4:0] rs2, input logic taken, input int off);
		add_step(1'b1, enc_b(off, rs2, rs1, f3), 1'b0, 5'd0, 32'h0, taken, taken ? off : 4);
	endtask

	task automatic build_table();
		alu_step(enc_i(100, 0, 3'b000, 1), 1, 32'd100);          // addi x1 = 100
		alu_step(enc_i(-7, 0, 3'b000, 2), 2, 32'hFFFF_FFF9);     // x2 = -7
		alu_step(enc_i(12'h7FF, 0, 3'b000, 3), 3, 32'd2047);     // largest positive imm
		alu_step(enc_i(-1, 1, 3'b000, 4), 4, 32'd99);            // rs1 + imm
		alu_step(enc_i(12'h800, 0, 3'b000, 5), 5, 32'hFFFF_F800); // most negative imm
		alu_step(enc_r(7'h00, 2, 1, 3'b000, 6), 6, 32'd93);      // add
		alu_step(enc_r(7'h20, 2, 1, 3'b000, 7), 7, 32'd107);     // sub
		alu_step(enc_r(7'h00, 4, 1, 3'b001, 8), 8, 32'd800);     // sll by 99 & 31 = 3
		alu_step(enc_r(7'h00, 1, 2, 3'b010, 9), 9, 32'd1);       // slt, -7 < 100
		alu_step(enc_r(7'h00, 1, 2, 3'b011, 10), 10, 32'd0);     // sltu, big unsigned
		alu_step(enc_r(7'h00, 2, 1, 3'b100, 11), 11, 32'hFFFF_FF9D);
		alu_step(enc_r(7'h00, 4, 2, 3'b101, 12), 12, 32'h1FFF_FFFF); // srl zero fill
		alu_step(enc_r(7'h20, 4, 2, 3'b101, 13), 13, 32'hFFFF_FFFF); // sra sign fill
		alu_step(enc_r(7'h00, 2, 1, 3'b110, 14), 14, 32'hFFFF_FFFD);
		alu_step(enc_r(7'h00, 2, 1, 3'b111, 15), 15, 32'h0000_0060);
		alu_step(enc_i(12'h004, 1, 3'b001, 16), 16, 32'h0000_0640);  // slli 4
		alu_step(enc_i(12'h01C, 2, 3'b101, 17), 17, 32'h0000_000F);  // srli 28
		alu_step(enc_i(12'h401, 2, 3'b101, 18), 18, 32'hFFFF_FFFC);  // srai 1
		branch_step(3'b000, 1, 1, 1'b1, 8);    // beq
		branch_step(3'b000, 1, 2, 1'b0, 8);
		branch_step(3'b001, 1, 2, 1'b1, 12);   // bne
		branch_step(3'b001, 1, 1, 1'b0, 12);
		branch_step(3'b100, 2, 1, 1'b1, 8);    // blt
		branch_step(3'b100, 1, 2, 1'b0, 8);
		branch_step(3'b101, 1, 2, 1'b1, 8);    // bge
		branch_step(3'b101, 2, 1, 1'b0, 8);
		branch_step(3'b110, 1, 2, 1'b1, 8);    // bltu
		branch_step(3'b110, 2, 1, 1'b0, 8);
		branch_step(3'b111, 2, 1, 1'b1, -16);  // bgeu, backwards
		branch_step(3'b111, 1, 2, 1'b0, 8);
		add_step(1'b1, enc_i(5, 1, 3'b000, 0), 1'b0, 5'd0, 32'h0, 1'b0, 4); // addi x0
		alu_step(enc_r(7'h00, 1, 0, 3'b000, 19), 19, 32'd100);   // x0 still reads zero
		add_step(1'b1, 32'h0000_00FF, 1'b0, 5'd0, 32'h0, 1'b0, 4); // unknown opcode
		add_step(1'b0, enc_i(55, 0, 3'b000, 20), 1'b0, 5'd0, 32'h0, 1'b0, 0); // idle
		add_step(1'b0, enc_b(8, 1, 1, 3'b000), 1'b0, 5'd0, 32'h0, 1'b0, 0);
		alu_step(enc_i(55, 0, 3'b000, 20), 20, 32'd55);
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// run limit from table length, reset and margin
	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout: run did not end within %0d cycles", cycle_limit);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		int errs_before;
		instr_valid = 1'b0;
		instr       = 32'h0;
		build_table();
		cycle_limit = steps.size() + 5 + 20;
		@(posedge rst_n);
		check_value("pc after reset", pc, 32'h0);
		foreach (steps[i]) begin
			errs_before = errors;
			@(negedge clk);
			instr_valid = steps[i].valid;
			instr       = steps[i].instr;
			#2; // combinational outputs settle mid low phase
			check_value("wb_en", wb_en, steps[i].we);
			if (steps[i].we) begin
				check_value("wb_rd", wb_rd, steps[i].rd);
				check_value("wb_data", wb_data, steps[i].data);
			end
			check_value("branch_taken", branch_taken, steps[i].taken);
			@(posedge clk);
			#1;
			check_value("next pc", pc, steps[i].next_pc);
			if (errors == errs_before) begin
				passed++;
				$display("step %0d instr %h: ok", i, steps[i].instr);
			end else begin
				failed++;
				$display("step %0d instr %h: mismatch", i, steps[i].instr);
			end
		end
		@(negedge clk);
		instr_valid = 1'b0;
		$display("steps passed: %0d, steps failed: %0d, assertion failures: %0d",
			passed, failed, dut.u_props.fail_count);
		if (errors == 0 && dut.u_props.fail_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: sim/exec_core_properties.sv
`timescale 1ns/10ps

module exec_core_properties (
	input logic                    i_clk,
	input logic                    i_rst_n,
	input logic                    i_instr_valid,
	input logic [rv_pkg::XLEN-1:0] i_pc,
	input logic                    i_wb_en,
	input logic                    i_branch_taken
);

	int fail_count = 0; // failed assertions so far

	// write-back only for a valid instruction
	a_wb_needs_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_wb_en |-> i_instr_valid)
		else begin
			fail_count++;
			$error("write-back enabled without a valid instruction");
		end

	// branches never write rd
	a_branch_no_wb: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(i_branch_taken && i_wb_en))
		else begin
			fail_count++;
			$error("taken branch together with write-back");
		end

	// idle cycle leaves pc alone
	a_pc_holds: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!i_instr_valid |=> $stable(i_pc))
		else begin
			fail_count++;
			$error("pc moved while no instruction was valid");
		end

	a_pc_reset: assert property (@(posedge i_clk)
		$rose(i_rst_n) |-> i_pc == rv_pkg::PC_RESET)
		else begin
			fail_count++;
			$error("pc not at reset vector after reset");
		end

endmodule

bind exec_core exec_core_properties u_props (
	.i_clk          (i_clk),
	.i_rst_n        (i_rst_n),
	.i_instr_valid  (i_instr_valid),
	.i_pc           (o_pc),
	.i_wb_en        (o_wb_en),
	.i_branch_taken (o_branch_taken)
);

// File: sim/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
	output logic o_clk,
	output logic o_rst_n
);

	initial begin
		o_clk = 1'b0;
		forever #5 o_clk = ~o_clk; // 10 ns period
	end

	// reset low for 5 cycles, released away from the rising edge
	initial begin
		o_rst_n = 1'b0;
		repeat (5) @(posedge o_clk);
		@(negedge o_clk);
		o_rst_n = 1'b1;
	end

endmodule

// File: src/exec_core.sv
`timescale 1ns/10ps

module exec_core (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  logic                    i_instr_valid,
	input  logic [31:0]             i_instr,
	output logic [rv_pkg::XLEN-1:0] o_pc,
	output logic                    o_wb_en,
	output logic [4:0]              o_wb_rd,
	output logic [rv_pkg::XLEN-1:0] o_wb_data,
	output logic                    o_branch_taken
);

	rv_pkg::ctrl_t           ctrl;
	rv_pkg::pc_sel_e         pc_sel;
	logic [rv_pkg::XLEN-1:0] rs1_data;
	logic [rv_pkg::XLEN-1:0] rs2_data;
	logic [rv_pkg::XLEN-1:0] alu_result;
	logic                    alu_taken;
	logic [rv_pkg::XLEN-1:0] pc_next;

	// decode and register read side by side
	instr_decoder u_decoder (
		.i_opcode    (i_instr[6:0]),
		.i_funct3    (i_instr[14:12]),
		.i_instr_30  (i_instr[30]),
		.i_imm_field (i_instr[31:7]),
		.o_ctrl      (ctrl)
	);

	reg_file u_reg_file (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_rs1      (i_instr[19:15]),
		.i_rs2      (i_instr[24:20]),
		.i_we       (o_wb_en),
		.i_rd       (o_wb_rd),
		.i_wdata    (o_wb_data),
		.o_rs1_data (rs1_data),
		.o_rs2_data (rs2_data)
	);

	alu u_alu (
		.i_ctrl     (ctrl),
		.i_rs1_data (rs1_data),
		.i_rs2_data (rs2_data),
		.i_shamt    (i_instr[24:20]), // shamt sits in the rs2 field
		.o_result   (alu_result),
		.o_taken    (alu_taken)
	);

	// write-back, only valid alu ops to a real rd
	assign o_wb_rd        = i_instr[11:7];
	assign o_wb_data      = alu_result;
	assign o_wb_en        = i_instr_valid & ctrl.reg_we & (o_wb_rd != 5'd0);
	assign o_branch_taken = i_instr_valid & alu_taken;

	// next pc
	assign pc_sel  = o_branch_taken ? rv_pkg::BRANCH : rv_pkg::PLUS4;
	assign pc_next = (pc_sel == rv_pkg::BRANCH) ? o_pc + ctrl.imm
						    : o_pc + 32'd4;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			o_pc <= rv_pkg::PC_RESET;
		else if (i_instr_valid)
			o_pc <= pc_next; // holds while no instruction
	end

endmodule

// File: src/alu.sv
`timescale 1ns/10ps

module alu (
	input  rv_pkg::ctrl_t           i_ctrl,
	input  logic [rv_pkg::XLEN-1:0] i_rs1_data,
	input  logic [rv_pkg::XLEN-1:0] i_rs2_data,
	input  logic [4:0]              i_shamt,   // rs2 field of the instruction
	output logic [rv_pkg::XLEN-1:0] o_result,
	output logic                    o_taken
);

	logic [rv_pkg::XLEN-1:0] op_a;
	logic [rv_pkg::XLEN-1:0] op_b;
	logic [4:0]              sh;    // shift amount
	logic                    lt_s;  // signed less-than
	logic                    lt_u;  // unsigned less-than
	logic                    cond;  // raw branch condition

	assign op_a = i_rs1_data;

	// operand b mux
	always_comb begin
		case (i_ctrl.b_sel)
			rv_pkg::IMM:   op_b = i_ctrl.imm;
			rv_pkg::SHAMT: op_b = {{(rv_pkg::XLEN-5){1'b0}}, i_shamt};
			default:       op_b = i_rs2_data;
		endcase
	end

	assign sh   = op_b[4:0]; // only low 5 bits count in rv32
	assign lt_s = $signed(op_a) < $signed(op_b);
	assign lt_u = op_a < op_b;

	always_comb begin
		case (i_ctrl.alu_fn)
			rv_pkg::ADD:  o_result = op_a + op_b;
			rv_pkg::SUB:  o_result = op_a - op_b;
			rv_pkg::SLL:  o_result = op_a << sh;
			rv_pkg::SLT:  o_result = {{(rv_pkg::XLEN-1){1'b0}}, lt_s};
			rv_pkg::SLTU: o_result = {{(rv_pkg::XLEN-1){1'b0}}, lt_u};
			rv_pkg::XOR:  o_result = op_a ^ op_b;
			rv_pkg::SRL:  o_result = op_a >> sh;
			rv_pkg::SRA:  o_result = $unsigned($signed(op_a) >>> sh); // sign fill
			rv_pkg::OR:   o_result = op_a | op_b;
			rv_pkg::AND:  o_result = op_a & op_b;
			rv_pkg::BGE:  o_result = {{(rv_pkg::XLEN-1){1'b0}}, ~lt_s}; // branch only
			rv_pkg::BGEU: o_result = {{(rv_pkg::XLEN-1){1'b0}}, ~lt_u}; // branch only
			default:      o_result = '0;
		endcase
	end

	// branch test on the same compare logic
	always_comb begin
		case (i_ctrl.alu_fn)
			rv_pkg::SUB:  cond = (o_result == '0) ^ i_ctrl.br_invert; // beq / bne
			rv_pkg::SLT:  cond = lt_s;
			rv_pkg::SLTU: cond = lt_u;
			rv_pkg::BGE:  cond = ~lt_s;
			rv_pkg::BGEU: cond = ~lt_u;
			default:      cond = 1'b0;
		endcase
	end

	assign o_taken = i_ctrl.is_branch & cond; // sub on r-type never branches

endmodule

// File: src/reg_file.sv
`timescale 1ns/10ps

module reg_file (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  logic [4:0]              i_rs1,
	input  logic [4:0]              i_rs2,
	input  logic                    i_we,
	input  logic [4:0]              i_rd,
	input  logic [rv_pkg::XLEN-1:0] i_wdata,
	output logic [rv_pkg::XLEN-1:0] o_rs1_data,
	output logic [rv_pkg::XLEN-1:0] o_rs2_data
);

	// x1..x31, x0 has no storage
	logic [rv_pkg::XLEN-1:0] regs [1:31];

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (i_we && i_rd != 5'd0) begin
			regs[i_rd] <= i_wdata; // x0 writes dropped
		end
	end

	// async reads, old value visible in a write cycle
	assign o_rs1_data = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
	assign o_rs2_data = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

endmodule

// File: src/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder (
	input  logic [6:0]   i_opcode,
	input  logic [2:0]   i_funct3,
	input  logic         i_instr_30,  // funct7 bit 5, picks sub/sra
	input  logic [31:7]  i_imm_field, // instruction bits kept at their own index
	output rv_pkg::ctrl_t o_ctrl
);

	rv_pkg::opcode_e cls;
	logic [rv_pkg::XLEN-1:0] imm_i; // i-format immediate
	logic [rv_pkg::XLEN-1:0] imm_b; // b-format immediate, lsb always zero

	// instruction class from the major opcode
	always_comb begin
		case (i_opcode)
			rv_pkg::OP_RTYPE: cls = rv_pkg::CLS_R;
			rv_pkg::OP_ITYPE: cls = rv_pkg::CLS_I;
			rv_pkg::OP_BTYPE: cls = rv_pkg::CLS_B;
			default:          cls = rv_pkg::CLS_NONE;
		endcase
	end

	// imm[11:0] = instr[31:20]
	assign imm_i = {{20{i_imm_field[31]}}, i_imm_field[31:20]};

	// imm[12|10:5|4:1|11] scattered over instr[31:25] and instr[11:7]
	assign imm_b = {{19{i_imm_field[31]}},
			i_imm_field[31],      // imm[12]
			i_imm_field[7],       // imm[11]
			i_imm_field[30:25],   // imm[10:5]
			i_imm_field[11:8],    // imm[4:1]
			1'b0};

	always_comb begin
		// safe defaults, nothing written and no branch
		o_ctrl.reg_we    = 1'b0;
		o_ctrl.b_sel     = rv_pkg::REG;
		o_ctrl.alu_fn    = rv_pkg::ADD;
		o_ctrl.is_branch = 1'b0;
		o_ctrl.br_invert = 1'b0;
		o_ctrl.imm       = '0;

		case (cls)
			rv_pkg::CLS_R: begin
				// bit 30 only legal on add/sub and srl/sra
				if (!i_instr_30 || i_funct3 == 3'b000 || i_funct3 == 3'b101) begin
					o_ctrl.reg_we = 1'b1;
					o_ctrl.alu_fn = rv_pkg::alu_fn_e'({i_instr_30, i_funct3});
				end
			end

			rv_pkg::CLS_I: begin
				o_ctrl.imm    = imm_i;
				o_ctrl.b_sel  = rv_pkg::IMM;
				o_ctrl.reg_we = 1'b1;
				case (i_funct3)
					3'b001: begin // slli
						o_ctrl.b_sel  = rv_pkg::SHAMT;
						o_ctrl.alu_fn = rv_pkg::SLL;
						o_ctrl.reg_we = !i_instr_30; // no slai in rv32i
					end
					3'b101: begin // srli / srai
						o_ctrl.b_sel  = rv_pkg::SHAMT;
						o_ctrl.alu_fn = i_instr_30 ? rv_pkg::SRA : rv_pkg::SRL;
					end
					// remaining ops ignore bit 30, it belongs to the immediate
					default: o_ctrl.alu_fn = rv_pkg::alu_fn_e'({1'b0, i_funct3});
				endcase
			end

			rv_pkg::CLS_B: begin
				o_ctrl.imm       = imm_b;
				o_ctrl.is_branch = 1'b1;
				case (i_funct3)
					3'b000: o_ctrl.alu_fn = rv_pkg::SUB;  // beq
					3'b001: begin                         // bne
						o_ctrl.alu_fn    = rv_pkg::SUB;
						o_ctrl.br_invert = 1'b1;
					end
					3'b100: o_ctrl.alu_fn = rv_pkg::SLT;  // blt
					3'b101: o_ctrl.alu_fn = rv_pkg::BGE;
					3'b110: o_ctrl.alu_fn = rv_pkg::SLTU; // bltu
					3'b111: o_ctrl.alu_fn = rv_pkg::BGEU;
					default: o_ctrl.is_branch = 1'b0;     // 010/011 undefined
				endcase
			end

			default: ; // unknown opcode, defaults hold
		endcase
	end

endmodule

// File: src/rv_pkg.sv
package rv_pkg;

	// datapath width and reset vector
	localparam int XLEN = 32;
	localparam logic [XLEN-1:0] PC_RESET = '0;

	// major opcodes, bits 6:0 of the instruction
	localparam logic [6:0] OP_RTYPE = 7'b0110011; // reg-reg alu
	localparam logic [6:0] OP_ITYPE = 7'b0010011; // reg-imm alu and shift-imm
	localparam logic [6:0] OP_BTYPE = 7'b1100011; // conditional branches

	// decoded instruction class
	typedef enum logic [1:0] {
		CLS_NONE, // unknown opcode
		CLS_R,
		CLS_I,
		CLS_B
	} opcode_e;

	// alu operation, encoded as {bit30, funct3}
	// branches share the compare codes
	typedef enum logic [3:0] {
		ADD  = 4'b0000, // add, addi
		SLL  = 4'b0001, // sll, slli
		SLT  = 4'b0010, // slt, slti, blt
		SLTU = 4'b0011, // sltu, sltiu, bltu
		XOR  = 4'b0100, // xor, xori
		SRL  = 4'b0101, // srl, srli
		OR   = 4'b0110, // or, ori
		AND  = 4'b0111, // and, andi
		SUB  = 4'b1000, // sub, beq, bne
		BGE  = 4'b1001,
		BGEU = 4'b1010,
		SRA  = 4'b1101  // sra, srai
	} alu_fn_e;

	// operand b source
	typedef enum logic [1:0] {
		REG,   // rs2 value
		IMM,   // sign-extended immediate
		SHAMT  // zero-extended rs2 field
	} b_sel_e;

	// next pc source
	typedef enum logic {
		PLUS4,
		BRANCH // pc + imm
	} pc_sel_e;

	// decoder to alu controls
	typedef struct packed {
		logic            reg_we;    // writes rd
		b_sel_e          b_sel;
		alu_fn_e         alu_fn;
		logic            is_branch;
		logic            br_invert; // bne flips the zero test
		logic [XLEN-1:0] imm;       // sign-extended, i or b format
	} ctrl_t;

endpackage
